//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := oflow_score_calc_tb
FILELIST  := sources.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the pass line shows up
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

//--- dv/oflow_score_calc_tb.sv
module oflow_score_calc_tb;
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// run budget
	// --------------------------------------------------

	localparam int NUM_RUNS     = 16;
	localparam int WRITE_CYCLES = MAX_OBJECTS + 2;
	localparam int MAX_PAIRS    = (MAX_OBJECTS + 1) / 2;
	localparam int RUN_SLACK    = 20;
	// reset and a few idle cycles on top
	localparam int TIMEOUT_CYCLES =
		NUM_RUNS * (WRITE_CYCLES + 5 + 6 * MAX_PAIRS + RUN_SLACK) + 10;

	// buffer fill modes
	localparam int FILL_RANDOM = 0;
	localparam int FILL_COPIES = 1;
	localparam int FILL_ZERO   = 2;

	logic         clk;
	logic         reset_N;
	logic         write_en;
	object_id_t   write_id;
	features_t    write_features;
	logic         start_score_calc;
	object_id_t   num_objects;
	features_t    query_features;
	best_match_t  result;
	logic         result_valid;

	// model copy of the buffer, indexed by id
	features_t model_mem [1:MAX_OBJECTS];

	logic [31:0] lfsr_state = 32'hcf870ca5;
	int cycle_count = 0;

	oflow_score_calc DUT (
		.clk(clk), .reset_N(reset_N),
		.write_en(write_en), .write_id(write_id), .write_features(write_features),
		.start_score_calc(start_score_calc), .num_objects(num_objects),
		.query_features(query_features),
		.result(result), .result_valid(result_valid)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// --------------------------------------------------
	// random numbers
	// --------------------------------------------------

	// galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'ha3000000;
		return n;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic features_t rand_features();
		features_t f;
		logic [31:0] r;
		for (int i = 0; i < FEATURE_COUNT; i++) begin
			r = take_bits(FEATURE_LEN);
			f[i] = r[FEATURE_LEN-1:0];
		end
		return f;
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	// sum of absolute field differences
	function automatic int field_sad(input features_t a, input features_t b);
		int sum;
		int d;
		sum = 0;
		for (int i = 0; i < FEATURE_COUNT; i++) begin
			d = int'(a[i]) - int'(b[i]);
			sum += (d < 0) ? -d : d;
		end
		return sum;
	endfunction

	// strict compare in id order, lowest id wins a tie
	function automatic best_match_t expected_match(input int num, input features_t q);
		best_match_t m;
		int best_score;
		int s;
		best_score = 1 << SCORE_LEN;
		m.id = '0;
		m.score = '1;
		for (int id = 1; id <= num; id++) begin
			s = field_sad(q, model_mem[id]);
			if (s < best_score) begin
				best_score = s;
				m.id = object_id_t'(id);
				m.score = score_t'(s);
			end
		end
		return m;
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_match(input best_match_t got, input best_match_t exp,
			input string what);
		if (got.id !== exp.id)
			report_failure($sformatf("ERROR at time %0t: %s, id %0d, expected %0d",
				$time, what, got.id, exp.id));
		else if (got.score !== exp.score)
			report_failure($sformatf("ERROR at time %0t: %s, score %0d, expected %0d",
				$time, what, got.score, exp.score));
	endtask

	// hang guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout: result_valid never came within %0d cycles",
				TIMEOUT_CYCLES));
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	// rewrites every id, copies land where the mask bit is set
	task automatic fill_buffer(input int mode, input logic [MAX_OBJECTS-1:0] copy_mask,
			input features_t copy_vec);
		features_t f;
		for (int id = 1; id <= MAX_OBJECTS; id++) begin
			if (mode == FILL_ZERO)
				f = '0;
			else if (mode == FILL_COPIES && copy_mask[id-1])
				f = copy_vec;
			else
				f = rand_features();
			@(negedge clk);
			write_en = 1'b1;
			write_id = object_id_t'(id);
			write_features = f;
			model_mem[id] = f;
		end
		@(negedge clk);
		write_en = 1'b0;
	endtask

	// one start pulse, then wait for the result pulse
	task automatic run_query(input int num, input features_t q, input string what);
		best_match_t exp;
		exp = expected_match(num, q);
		@(negedge clk);
		start_score_calc = 1'b1;
		num_objects = object_id_t'(num);
		query_features = q;
		@(negedge clk);
		start_score_calc = 1'b0;
		while (!result_valid)
			@(negedge clk);
		check_match(result, exp, what);
		@(negedge clk);
		if (result_valid)
			report_failure("result_valid stayed high for more than one cycle");
	endtask

	initial begin
		features_t v;
		logic [31:0] r;
		int num;

		reset_N = 1'b0;
		write_en = 1'b0;
		write_id = '0;
		write_features = '0;
		start_score_calc = 1'b0;
		num_objects = '0;
		query_features = '0;
		repeat (2) @(negedge clk);
		reset_N = 1'b1;

		// single object, exact match parked at id 2 must not count
		v = rand_features();
		fill_buffer(FILL_COPIES, 8'b0000_0010, v);
		run_query(1, v, "single object");

		// odd counts, only match in the half empty last pair
		for (int n = 3; n <= 7; n += 2) begin
			v = rand_features();
			fill_buffer(FILL_COPIES, MAX_OBJECTS'(1) << (n - 1), v);
			run_query(n, v, "odd count");
		end

		// four pairs on both lanes
		fill_buffer(FILL_RANDOM, '0, '0);
		run_query(MAX_OBJECTS, rand_features(), "full buffer");

		// ids 3 and 4 share a pair, 7 comes later
		v = rand_features();
		fill_buffer(FILL_COPIES, 8'b0100_1100, v);
		run_query(8, v, "tie inside pair");
		// ids 2, 6, 8 all on lane 1
		v = rand_features();
		fill_buffer(FILL_COPIES, 8'b1010_0010, v);
		run_query(8, v, "tie across pairs");
		// ids 5 and 7 with an empty last slot
		v = rand_features();
		fill_buffer(FILL_COPIES, 8'b0101_0000, v);
		run_query(7, v, "tie odd count");

		// 4 * 1023 everywhere, id 1 wins
		fill_buffer(FILL_ZERO, '0, '0);
		run_query(MAX_OBJECTS, '1, "max score");

		// back to back, fresh buffer each time
		for (int k = 0; k < NUM_RUNS - 9; k++) begin
			r = take_bits(3);
			num = int'(r[2:0]) + 1;
			fill_buffer(FILL_RANDOM, '0, '0);
			run_query(num, rand_features(), "random run");
		end

		$display("TEST OK");
		$finish;
	end

endmodule

//--- logic/oflow_buffer_reader.sv
module oflow_buffer_reader (
	input  logic                         clk,
	input  logic                         reset_N,

	// write port
	input  logic                         write_en,
	input  oflow_core_pkg::object_id_t   write_id,
	input  oflow_core_pkg::features_t    write_features,

	// run control
	input  logic                         start_score_calc,
	input  oflow_core_pkg::object_id_t   num_objects,
	input  logic                         done_similarity_metric,

	// to lanes and controller
	output oflow_core_pkg::object_pair_t pair,
	output logic                         done_read
);
	import oflow_core_pkg::*;

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------

	// one entry per stored id, no reset on the array
	features_t mem [MAX_OBJECTS];

	// object count latched at start
	object_id_t count;

	// first id of the pair still to be loaded
	object_id_t next_id;

	// id n lives at entry n-1
	function automatic logic [BUF_ADDR_LEN-1:0] id_to_addr(input object_id_t id);
		object_id_t idx;
		idx = id - ID_LEN'(1);
		return idx[BUF_ADDR_LEN-1:0];
	endfunction

	// ids first and first+1, second slot empty past the count
	function automatic object_pair_t make_pair(input object_id_t first_id,
			input object_id_t cnt);
		object_pair_t p;
		object_id_t second_id;
		second_id = first_id + ID_LEN'(1);
		p.id_0 = first_id;
		p.id_1 = (second_id <= cnt) ? second_id : '0;
		p.features_0 = mem[id_to_addr(first_id)];
		p.features_1 = mem[id_to_addr(second_id)];
		return p;
	endfunction

	// plain write port
	always_ff @(posedge clk) begin
		if (write_en)
			mem[id_to_addr(write_id)] <= write_features;
	end

	// --------------------------------------------------
	// pair walk
	// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pair      <= '0;
			count     <= '0;
			next_id   <= '0;
			done_read <= 1'b0;
		end else begin
			// pulse only
			done_read <= 1'b0;
			if (start_score_calc) begin
				// pair 0 is ids 1 and 2
				pair      <= make_pair(ID_LEN'(1), num_objects);
				count     <= num_objects;
				next_id   <= ID_LEN'(3);
				done_read <= (num_objects <= ID_LEN'(2));
			end else if (done_similarity_metric && (next_id <= count)) begin
				// advance once the lanes finish, nothing after the last pair
				pair      <= make_pair(next_id, count);
				next_id   <= next_id + ID_LEN'(2);
				done_read <= (next_id + ID_LEN'(1) >= count);
			end
		end
	end

	// count must name at least one stored object and fit the buffer
	assert property (@(posedge clk) disable iff (!reset_N)
		start_score_calc |-> (num_objects != '0) && (num_objects <= ID_LEN'(MAX_OBJECTS)));

endmodule

//--- logic/oflow_core_pkg.sv
package oflow_core_pkg;

	// --------------------------------------------------
	// object identifiers
	// --------------------------------------------------

	// id 0 marks an empty slot, stored ids run 1..MAX_OBJECTS
	localparam int ID_LEN = 4;

	// buffer depth
	localparam int MAX_OBJECTS = 8;

	// buffer address, one entry per stored id
	localparam int BUF_ADDR_LEN = $clog2(MAX_OBJECTS);

	typedef logic [ID_LEN-1:0] object_id_t;

	// --------------------------------------------------
	// feature vectors
	// --------------------------------------------------

	// centre x, centre y, width, height
	localparam int FEATURE_COUNT = 4;

	// bits per field
	localparam int FEATURE_LEN = 10;

	// field index inside one vector
	localparam int FEATURE_IDX_LEN = $clog2(FEATURE_COUNT);

	// field 0 sits in the low bits
	typedef logic [FEATURE_COUNT-1:0][FEATURE_LEN-1:0] features_t;

	// --------------------------------------------------
	// buffer to metric lanes
	// --------------------------------------------------

	// two stored objects side by side
	// id_1 zero when the second slot is empty
	typedef struct packed {
		object_id_t id_0;
		object_id_t id_1;
		features_t  features_0;
		features_t  features_1;
	} object_pair_t;

endpackage

//--- logic/oflow_score_calc.sv
module oflow_score_calc (
	input  logic                         clk,
	input  logic                         reset_N,

	// buffer fill
	input  logic                         write_en,
	input  oflow_core_pkg::object_id_t   write_id,
	input  oflow_core_pkg::features_t    write_features,

	// run request
	input  logic                         start_score_calc,
	input  oflow_core_pkg::object_id_t   num_objects,
	input  oflow_core_pkg::features_t    query_features,

	// best match
	output oflow_score_pkg::best_match_t result,
	output logic                         result_valid
);
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------

	// new object, held for the whole run
	features_t query_q;

	object_pair_t pair;
	logic done_read;
	logic start_sm_0;
	logic start_sm_1;
	logic done_sm_0;
	logic done_sm_1;
	score_t score_0;
	score_t score_1;
	logic done_score_calc;

	always_ff @(posedge clk) begin
		if (start_score_calc)
			query_q <= query_features;
	end

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------

	oflow_buffer_reader u_reader (
		.clk(clk), .reset_N(reset_N),
		.write_en(write_en), .write_id(write_id), .write_features(write_features),
		.start_score_calc(start_score_calc), .num_objects(num_objects),
		.done_similarity_metric(done_sm_0), .pair(pair), .done_read(done_read)
	);

	// lane 0 on the first slot, lane 1 on the second
	oflow_similarity_metric u_lane_0 (
		.clk(clk), .reset_N(reset_N), .start(start_sm_0),
		.query(query_q), .candidate(pair.features_0),
		.done(done_sm_0), .score(score_0)
	);

	oflow_similarity_metric u_lane_1 (
		.clk(clk), .reset_N(reset_N), .start(start_sm_1),
		.query(query_q), .candidate(pair.features_1),
		.done(done_sm_1), .score(score_1)
	);

	// equal latency, lane 0 done paces the run
	oflow_score_calc_similarity_metric_fsm u_ctrl (
		.clk(clk), .reset_N(reset_N),
		.start_score_calc(start_score_calc), .done_score_calc(done_score_calc),
		.done_read(done_read), .id_1(pair.id_1),
		.done_similarity_metric(done_sm_0),
		.start_similarity_metric_0(start_sm_0), .start_similarity_metric_1(start_sm_1)
	);

	oflow_score_select u_select (
		.clk(clk), .reset_N(reset_N), .start_score_calc(start_score_calc),
		.done_0(done_sm_0), .score_0(score_0), .done_1(done_sm_1), .score_1(score_1),
		.pair(pair), .done_score_calc(done_score_calc),
		.result(result), .result_valid(result_valid)
	);

endmodule

//--- logic/oflow_score_calc_similarity_metric_fsm.sv
module oflow_score_calc_similarity_metric_fsm (
	input  logic                       clk,
	input  logic                       reset_N,

	// run control
	input  logic                       start_score_calc,
	output logic                       done_score_calc,

	// buffer side
	input  logic                       done_read,
	input  oflow_core_pkg::object_id_t id_1,

	// lanes
	input  logic                       done_similarity_metric,
	output logic                       start_similarity_metric_0,
	output logic                       start_similarity_metric_1
);

	// --------------------------------------------------
	// state
	// --------------------------------------------------

	typedef enum logic [1:0] {
		idle_st,
		similarity_metric_st,
		wait_st
	} sm_type;

	sm_type current_state;
	sm_type next_state;

	// pair on the lanes is the final one
	logic last;

	// relaunch in the cycle after a done
	logic flg_start_similarity_metric;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			current_state <= idle_st;
		else
			current_state <= next_state;
	end

	// set by the reader, dropped with the final done
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			last <= 1'b0;
		else if (done_read)
			last <= 1'b1;
		else if (done_similarity_metric && last)
			last <= 1'b0;
	end

	// only a wait to metric move relaunches
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			flg_start_similarity_metric <= 1'b0;
		else
			flg_start_similarity_metric <= (current_state == wait_st) &&
				(next_state == similarity_metric_st);
	end

	// --------------------------------------------------
	// next state and pulses
	// --------------------------------------------------

	always_comb begin
		next_state = current_state;
		start_similarity_metric_0 = 1'b0;
		start_similarity_metric_1 = 1'b0;
		done_score_calc = 1'b0;

		case (current_state)
			idle_st: begin
				if (start_score_calc) begin
					// pair 0 loads at this edge, id_1 still stale here
					// lane 1 always runs for the first pair
					// empty second slot dropped at the selector
					start_similarity_metric_0 = 1'b1;
					start_similarity_metric_1 = 1'b1;
					next_state = similarity_metric_st;
				end
			end

			similarity_metric_st: begin
				if (flg_start_similarity_metric) begin
					start_similarity_metric_0 = 1'b1;
					// second lane only for a real object
					start_similarity_metric_1 = |id_1;
				end
				next_state = wait_st;
			end

			wait_st: begin
				if (done_similarity_metric && !last) begin
					next_state = similarity_metric_st;
				end else if (done_similarity_metric && last) begin
					done_score_calc = 1'b1;
					next_state = idle_st;
				end
			end

			default: next_state = idle_st;
		endcase
	end

	// lane 0 done only after a launch, never mid-setup
	assert property (@(posedge clk) disable iff (!reset_N)
		done_similarity_metric |-> current_state == wait_st);

endmodule

//--- logic/oflow_score_pkg.sv
package oflow_score_pkg;

	// --------------------------------------------------
	// score width
	// --------------------------------------------------

	// worst case is FEATURE_COUNT * 1023 = 4092
	// twelve bits hold it with a little room
	localparam int SCORE_LEN = 12;

	// lower score means a closer match
	typedef logic [SCORE_LEN-1:0] score_t;

	// --------------------------------------------------
	// best match
	// --------------------------------------------------

	// winning stored object and its distance
	// id 0 only before any lane has reported
	typedef struct packed {
		oflow_core_pkg::object_id_t id;
		score_t                     score;
	} best_match_t;

endpackage

//--- logic/oflow_score_select.sv
module oflow_score_select (
	input  logic                         clk,
	input  logic                         reset_N,

	input  logic                         start_score_calc,

	// lane results
	input  logic                         done_0,
	input  oflow_score_pkg::score_t      score_0,
	input  logic                         done_1,
	input  oflow_score_pkg::score_t      score_1,

	// ids of the pair the lanes just scored
	input  oflow_core_pkg::object_pair_t pair,

	input  logic                         done_score_calc,
	output oflow_score_pkg::best_match_t result,
	output logic                         result_valid
);
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// running minimum
	// --------------------------------------------------

	best_match_t best;
	best_match_t best_next;

	// lane 0 first, strict compare keeps the lower id on a tie
	always_comb begin
		best_next = best;
		if (done_0 && (score_0 < best_next.score))
			best_next = '{id: pair.id_0, score: score_0};
		// empty second slot never counts
		if (done_1 && (pair.id_1 != '0) && (score_1 < best_next.score))
			best_next = '{id: pair.id_1, score: score_1};
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			best <= '{id: '0, score: '1};
		else if (start_score_calc)
			best <= '{id: '0, score: '1};
		else
			best <= best_next;
	end

	// --------------------------------------------------
	// result
	// --------------------------------------------------

	// last pair folded in on the same edge
	always_ff @(posedge clk) begin
		if (done_score_calc)
			result <= best_next;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			result_valid <= 1'b0;
		else
			result_valid <= done_score_calc;
	end

	// lanes launch together and share latency
	assert property (@(posedge clk) disable iff (!reset_N) done_1 |-> done_0);

endmodule

//--- logic/oflow_similarity_metric.sv
module oflow_similarity_metric (
	input  logic                       clk,
	input  logic                       reset_N,

	// launch, one cycle
	input  logic                       start,

	// both vectors stay put for the whole pair
	input  oflow_core_pkg::features_t  query,
	input  oflow_core_pkg::features_t  candidate,

	// result
	output logic                       done,
	output oflow_score_pkg::score_t    score
);
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// field datapath
	// --------------------------------------------------

	logic busy;
	logic [FEATURE_IDX_LEN-1:0] field_idx;
	logic [FEATURE_LEN-1:0] q_field;
	logic [FEATURE_LEN-1:0] c_field;
	logic [FEATURE_LEN-1:0] abs_diff;
	logic last_field;
	score_t acc;

	// one field per cycle
	always_comb begin
		q_field = query[field_idx];
		c_field = candidate[field_idx];
		// unsigned fields, subtract the smaller one
		if (q_field > c_field)
			abs_diff = q_field - c_field;
		else
			abs_diff = c_field - q_field;
	end

	assign last_field = (field_idx == FEATURE_IDX_LEN'(FEATURE_COUNT - 1));

	// --------------------------------------------------
	// sequencing
	// --------------------------------------------------

	// start edge arms the lane, fields follow in the next FEATURE_COUNT cycles
	// done lands FEATURE_COUNT+1 cycles after start
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy      <= 1'b0;
			field_idx <= '0;
			done      <= 1'b0;
		end else begin
			done <= busy && last_field;
			if (start) begin
				busy      <= 1'b1;
				field_idx <= '0;
			end else if (busy) begin
				field_idx <= field_idx + FEATURE_IDX_LEN'(1);
				if (last_field)
					busy <= 1'b0;
			end
		end
	end

	// accumulator cleared by start, holds after done
	always_ff @(posedge clk) begin
		if (start)
			acc <= '0;
		else if (busy)
			acc <= acc + score_t'(abs_diff);
	end

	assign score = acc;

	// controller only relaunches after done
	assert property (@(posedge clk) disable iff (!reset_N) start |-> !busy);

endmodule

//--- sources.f
logic/oflow_core_pkg.sv
logic/oflow_score_pkg.sv
logic/oflow_buffer_reader.sv
logic/oflow_similarity_metric.sv
logic/oflow_score_calc_similarity_metric_fsm.sv
logic/oflow_score_select.sv
logic/oflow_score_calc.sv
dv/oflow_score_calc_tb.sv
